// File: src/rvCorePkg.sv
/*
 * Shared definitions for the RV32I-subset core
 * Word and register index types, opcodes, ALU operation codes,
 * writeback select codes, data bus states and the NOP instruction
 */
package rvCorePkg;

   typedef logic [31:0] word;
   typedef logic [4:0]  regIdx;
   typedef logic [3:0]  aluOp;

   // Base opcodes
   localparam logic [6:0] opLui    = 7'b0110111;
   localparam logic [6:0] opAuipc  = 7'b0010111;
   localparam logic [6:0] opJal    = 7'b1101111;
   localparam logic [6:0] opJalr   = 7'b1100111;
   localparam logic [6:0] opBranch = 7'b1100011;
   localparam logic [6:0] opLoad   = 7'b0000011;
   localparam logic [6:0] opStore  = 7'b0100011;
   localparam logic [6:0] opOpImm  = 7'b0010011;
   localparam logic [6:0] opOp     = 7'b0110011;

   // ALU operations, low bits follow funct3 where possible
   localparam aluOp aluAdd   = 4'b0000;
   localparam aluOp aluSll   = 4'b0001;
   localparam aluOp aluSlt   = 4'b0010;
   localparam aluOp aluSltu  = 4'b0011;
   localparam aluOp aluXor   = 4'b0100;
   localparam aluOp aluSrl   = 4'b0101;
   localparam aluOp aluOr    = 4'b0110;
   localparam aluOp aluAnd   = 4'b0111;
   localparam aluOp aluSub   = 4'b1000;
   localparam aluOp aluSra   = 4'b1101;
   localparam aluOp aluPassB = 4'b1111;

   // Writeback value select
   localparam logic [1:0] selAlu  = 2'd0;
   localparam logic [1:0] selLoad = 2'd1;
   localparam logic [1:0] selLink = 2'd2;

   // addi x0,x0,0
   localparam word nopWord = 32'h00000013;

   typedef enum logic {busIdle, busWait} busState;

endpackage

// File: src/regFile.sv
/*
 * Integer register file
 * 32 x 32 bits, two combinational read ports, one write port.
 * Register x0 reads as zero and ignores writes.
 */
`timescale 1ns/1ps

module regFile import rvCorePkg::*;
(
   input  logic  clk,
   input  logic  rst,
   input  regIdx readA,
   input  regIdx readB,
   input  regIdx writeIdx,
   input  word   writeData,
   input  logic  writeEn,
   output word   dataA,
   output word   dataB
);

   word regs [32];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < 32; i++)
            regs[i] <= '0;
      end
      else if (writeEn && writeIdx != '0)
         regs[writeIdx] <= writeData;
   end

   assign dataA = (readA == '0) ? '0 : regs[readA];
   assign dataB = (readB == '0) ? '0 : regs[readB];

endmodule

// File: src/rvFetch.sv
/*
 * Fetch stage
 * Program counter with redirect from execute and hold on a data stall.
 * Raises squash for the word that arrives after a redirect or reset.
 */
`timescale 1ns/1ps

module rvFetch import rvCorePkg::*;
#(
   parameter word resetVector = 32'h0
)
(
   input  logic clk,
   input  logic rst,
   input  logic stall,
   input  logic redirect,
   input  word  target,
   output word  pc,
   output word  imemAddr,
   output logic imemEn,
   output logic squash
);

   word pcNext;

   assign pcNext   = pc + 32'd4;
   assign imemAddr = pc;
   // Memory output must stay put while execute is stalled
   assign imemEn   = ~stall;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc     <= resetVector;
         squash <= 1'b1;
      end
      else if (redirect)
      begin
         pc     <= target;
         squash <= 1'b1;
      end
      else if (!stall)
      begin
         pc     <= pcNext;
         squash <= 1'b0;
      end
   end

endmodule

// File: src/rvDecode.sv
/*
 * Decode stage
 * Splits the fetched word, builds the immediate and control bits,
 * reads the register file and forwards the writeback value.
 */
`timescale 1ns/1ps

module rvDecode import rvCorePkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       stall,
   input  word        imemData,
   input  logic       squash,
   input  word        fetchPc,
   input  word        wbValue,
   input  regIdx      wbRd,
   input  logic       wbWrite,
   output word        opA,
   output word        opB,
   output word        storeData,
   output word        imm,
   output word        xPc,
   output aluOp       op,
   output logic       useImm,
   output logic       isLui,
   output logic       isAuipc,
   output logic       isBranch,
   output logic       isJal,
   output logic       isJalr,
   output logic       isLoad,
   output logic       isStore,
   output logic [2:0] funct3,
   output regIdx      rd,
   output logic       rdWrite
);

   word        inst;
   logic [6:0] opcode;
   regIdx      rs1;
   regIdx      rs2;
   logic       funct7b5;
   word        rfA;
   word        rfB;
   logic       isOpImm;
   logic       isOp;

   // Pc travels with the word the memory returns one cycle later
   always_ff @(posedge clk)
   begin
      if (rst)
         xPc <= '0;
      else if (!stall)
         xPc <= fetchPc;
   end

   assign inst     = squash ? nopWord : imemData;
   assign opcode   = inst[6:0];
   assign rd       = inst[11:7];
   assign funct3   = inst[14:12];
   assign rs1      = inst[19:15];
   assign rs2      = inst[24:20];
   assign funct7b5 = inst[30];

   assign isLui    = (opcode == opLui);
   assign isAuipc  = (opcode == opAuipc);
   assign isJal    = (opcode == opJal);
   assign isJalr   = (opcode == opJalr);
   assign isBranch = (opcode == opBranch);
   assign isLoad   = (opcode == opLoad);
   assign isStore  = (opcode == opStore);
   assign isOpImm  = (opcode == opOpImm);
   assign isOp     = (opcode == opOp);

   assign useImm  = isOpImm | isLoad | isStore | isJalr | isLui | isAuipc;
   assign rdWrite = isLui | isAuipc | isJal | isJalr | isLoad | isOpImm | isOp;

   always_comb
   begin
      unique case (1'b1)
         isStore:         imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
         isBranch:        imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                 inst[11:8], 1'b0};
         isLui, isAuipc:  imm = {inst[31:12], 12'b0};
         isJal:           imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                 inst[30:21], 1'b0};
         default:         imm = {{20{inst[31]}}, inst[31:20]};
      endcase
   end

   always_comb
   begin
      op = aluAdd;
      if (isLui)
         op = aluPassB;
      else if (isOp || isOpImm)
      begin
         op = aluOp'({1'b0, funct3});
         // Bit 30 picks sub for OP only, sra for both groups
         if (funct3 == 3'b101 && funct7b5)
            op = aluSra;
         else if (funct3 == 3'b000 && funct7b5 && isOp)
            op = aluSub;
      end
   end

   regFile regs (
      .clk       (clk),
      .rst       (rst),
      .readA     (rs1),
      .readB     (rs2),
      .writeIdx  (wbRd),
      .writeData (wbValue),
      .writeEn   (wbWrite),
      .dataA     (rfA),
      .dataB     (rfB)
   );

   // Bypass from writeback, x0 never forwarded
   assign opA = (wbWrite && wbRd != '0 && wbRd == rs1) ? wbValue : rfA;
   assign opB = (wbWrite && wbRd != '0 && wbRd == rs2) ? wbValue : rfB;
   // Keep the bus data quiet unless a store is in execute
   assign storeData = isStore ? opB : '0;

endmodule

// File: src/rvExecute.sv
/*
 * Execute stage
 * ALU, branch decision and target, link value, and the Wishbone
 * classic data master that stalls the pipe for loads and stores.
 */
`timescale 1ns/1ps

module rvExecute import rvCorePkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  word        opA,
   input  word        opB,
   input  word        storeData,
   input  word        imm,
   input  word        xPc,
   input  aluOp       op,
   input  logic       useImm,
   input  logic       isLui,
   input  logic       isAuipc,
   input  logic       isBranch,
   input  logic       isJal,
   input  logic       isJalr,
   input  logic       isLoad,
   input  logic       isStore,
   input  logic [2:0] funct3,
   input  regIdx      rd,
   input  logic       rdWrite,
   input  word        wbDatR,
   input  logic       wbAck,
   output logic       wbCyc,
   output logic       wbStb,
   output logic       wbWe,
   output logic [3:0] wbSel,
   output word        wbAdr,
   output word        wbDatW,
   output logic       stall,
   output logic       redirect,
   output word        target,
   output word        aluResult,
   output word        loadData,
   output word        linkValue,
   output logic [1:0] resultSel,
   output regIdx      exRd,
   output logic       exWrite
);

   word     aluA;
   word     aluB;
   logic    cond;
   logic    memReq;
   busState state;

   assign aluA = isAuipc ? xPc : opA;
   assign aluB = useImm ? imm : opB;

   always_comb
   begin
      case (op)
         aluSub:   aluResult = aluA - aluB;
         aluSll:   aluResult = aluA << aluB[4:0];
         aluSlt:   aluResult = {31'b0, $signed(aluA) < $signed(aluB)};
         aluSltu:  aluResult = {31'b0, aluA < aluB};
         aluXor:   aluResult = aluA ^ aluB;
         aluSrl:   aluResult = aluA >> aluB[4:0];
         aluSra:   aluResult = word'($signed(aluA) >>> aluB[4:0]);
         aluOr:    aluResult = aluA | aluB;
         aluAnd:   aluResult = aluA & aluB;
         aluPassB: aluResult = aluB;
         default:  aluResult = aluA + aluB;
      endcase
   end

   // Branch compare on the register operands
   always_comb
   begin
      case (funct3)
         3'b000:  cond = (opA == opB);
         3'b001:  cond = (opA != opB);
         3'b100:  cond = ($signed(opA) < $signed(opB));
         3'b101:  cond = ($signed(opA) >= $signed(opB));
         3'b110:  cond = (opA < opB);
         3'b111:  cond = (opA >= opB);
         default: cond = 1'b0;
      endcase
   end

   assign redirect  = (isBranch & cond) | isJal | isJalr;
   assign target    = isJalr ? {aluResult[31:1], 1'b0} : xPc + imm;
   assign linkValue = xPc + 32'd4;
   assign resultSel = isLoad ? selLoad : ((isJal | isJalr) ? selLink : selAlu);
   assign exRd      = rd;

   // Data master, one single access per load or store
   assign memReq = isLoad | isStore;

   always_ff @(posedge clk)
   begin
      if (rst)
         state <= busIdle;
      else
      begin
         case (state)
            busIdle: if (memReq) state <= busWait;
            busWait: if (wbAck) state <= busIdle;
            default: state <= busIdle;
         endcase
      end
   end

   // Request cycle stalls too, so the pipe never moves before ack
   assign stall   = (state == busIdle) ? memReq : ~wbAck;
   assign exWrite = rdWrite & ~stall;

   assign wbCyc    = (state == busWait);
   assign wbStb    = wbCyc;
   assign wbWe     = isStore;
   assign wbSel    = 4'hF;
   assign wbAdr    = aluResult;
   assign wbDatW   = storeData;
   assign loadData = wbDatR;

endmodule

// File: src/rvResult.sv
/*
 * Writeback stage
 * Registers the execute results and picks the value for rd,
 * which also feeds the forwarding path in decode.
 */
`timescale 1ns/1ps

module rvResult import rvCorePkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  word        aluResult,
   input  word        loadData,
   input  word        linkValue,
   input  logic [1:0] resultSel,
   input  regIdx      exRd,
   input  logic       exWrite,
   output word        wbValue,
   output regIdx      wbRd,
   output logic       wbWrite
);

   word        aluQ;
   word        loadQ;
   word        linkQ;
   logic [1:0] selQ;

   always_ff @(posedge clk)
   begin
      aluQ  <= aluResult;
      loadQ <= loadData;
      linkQ <= linkValue;
      selQ  <= resultSel;
      wbRd  <= exRd;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         wbWrite <= 1'b0;
      else
         wbWrite <= exWrite;
   end

   always_comb
   begin
      case (selQ)
         selLoad: wbValue = loadQ;
         selLink: wbValue = linkQ;
         default: wbValue = aluQ;
      endcase
   end

endmodule

// File: src/rvCore.sv
/*
 * RV32I-subset core, three stages
 * Fetch from a one-cycle synchronous instruction port, execute with
 * a Wishbone classic data master, writeback with forwarding.
 */
`timescale 1ns/1ps

module rvCore import rvCorePkg::*;
#(
   parameter word resetVector = 32'h0
)
(
   input  logic       clk,
   input  logic       rst,
   output word        imemAddr,
   input  word        imemData,
   output logic       imemEn,
   output logic       wbCyc,
   output logic       wbStb,
   output logic       wbWe,
   output logic [3:0] wbSel,
   output word        wbAdr,
   output word        wbDatW,
   input  word        wbDatR,
   input  logic       wbAck
);

   word        fetchPc, target, opA, opB, storeData, imm, xPc;
   word        aluResult, loadData, linkValue, wbValue;
   logic       stall, redirect, squash, exWrite, wbWrite, rdWrite;
   logic       useImm, isLui, isAuipc, isBranch, isJal, isJalr, isLoad, isStore;
   logic [2:0] funct3;
   logic [1:0] resultSel;
   aluOp       op;
   regIdx      rd, exRd, wbRd;

   rvFetch #(.resetVector(resetVector)) fetch (
      .clk(clk), .rst(rst), .stall(stall), .redirect(redirect), .target(target),
      .pc(fetchPc), .imemAddr(imemAddr), .imemEn(imemEn), .squash(squash)
   );

   rvDecode decode (
      .clk(clk), .rst(rst), .stall(stall), .imemData(imemData), .squash(squash),
      .fetchPc(fetchPc), .wbValue(wbValue), .wbRd(wbRd), .wbWrite(wbWrite),
      .opA(opA), .opB(opB), .storeData(storeData), .imm(imm), .xPc(xPc), .op(op),
      .useImm(useImm), .isLui(isLui), .isAuipc(isAuipc), .isBranch(isBranch),
      .isJal(isJal), .isJalr(isJalr), .isLoad(isLoad), .isStore(isStore),
      .funct3(funct3), .rd(rd), .rdWrite(rdWrite)
   );

   rvExecute execute (
      .clk(clk), .rst(rst), .opA(opA), .opB(opB), .storeData(storeData),
      .imm(imm), .xPc(xPc), .op(op), .useImm(useImm), .isLui(isLui),
      .isAuipc(isAuipc), .isBranch(isBranch), .isJal(isJal), .isJalr(isJalr),
      .isLoad(isLoad), .isStore(isStore), .funct3(funct3), .rd(rd),
      .rdWrite(rdWrite), .wbDatR(wbDatR), .wbAck(wbAck), .wbCyc(wbCyc),
      .wbStb(wbStb), .wbWe(wbWe), .wbSel(wbSel), .wbAdr(wbAdr), .wbDatW(wbDatW),
      .stall(stall), .redirect(redirect), .target(target), .aluResult(aluResult),
      .loadData(loadData), .linkValue(linkValue), .resultSel(resultSel),
      .exRd(exRd), .exWrite(exWrite)
   );

   rvResult result (
      .clk(clk), .rst(rst), .aluResult(aluResult), .loadData(loadData),
      .linkValue(linkValue), .resultSel(resultSel), .exRd(exRd),
      .exWrite(exWrite), .wbValue(wbValue), .wbRd(wbRd), .wbWrite(wbWrite)
   );

endmodule

// File: verification/clockGen.sv
/*
 * Testbench clock and reset
 * 10 ns clock, reset held high for the first 5 rising edges
 */
`timescale 1ns/1ps

module clockGen
(
   output logic clk,
   output logic rst
);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial
   begin
      rst = 1'b1;
      repeat (5) @(posedge clk);
      #1 rst = 1'b0;
   end

endmodule

// File: verification/rvCore_chk.sv
/*
 * Bound protocol checks for the core
 * Reset state, Wishbone classic handshake rules on the data port
 * and alignment of the instruction address
 */
`timescale 1ns/1ps

module rvCore_chk
(
   input logic        clk,
   input logic        rst,
   input logic        wbCyc,
   input logic        wbStb,
   input logic        wbWe,
   input logic        wbAck,
   input logic [31:0] wbAdr,
   input logic [31:0] wbDatW,
   input logic [31:0] imemAddr
);

   resetQuiet: assert property (@(posedge clk) rst |-> !wbCyc)
      else $error("Bus cycle active during reset");

   // First fetch after reset comes from the reset vector
   resetFetch: assert property (@(posedge clk) rst |=> (imemAddr == 32'h0))
      else $error("Fetch address after reset is not the reset vector");

   stbNeedsCyc: assert property (@(posedge clk) disable iff (rst) wbStb |-> wbCyc)
      else $error("Strobe raised without cycle");

   holdUntilAck: assert property (@(posedge clk) disable iff (rst)
      (wbStb && !wbAck) |=> ($stable(wbAdr) && $stable(wbWe) && $stable(wbDatW)))
      else $error("Request changed before acknowledge");

   dropAfterAck: assert property (@(posedge clk) disable iff (rst)
      (wbStb && wbAck) |=> !wbStb)
      else $error("Strobe still high after acknowledge");

   alignedFetch: assert property (@(posedge clk) disable iff (rst)
      imemAddr[1:0] == 2'b00)
      else $error("Instruction address not word aligned");

endmodule

bind rvCore rvCore_chk chk (
   .clk      (clk),
   .rst      (rst),
   .wbCyc    (wbCyc),
   .wbStb    (wbStb),
   .wbWe     (wbWe),
   .wbAck    (wbAck),
   .wbAdr    (wbAdr),
   .wbDatW   (wbDatW),
   .imemAddr (imemAddr)
);

// File: verification/rvCoreTb.sv
/*
 * Testbench for the RV32I-subset core
 * Runs the test program from a synchronous instruction memory, answers
 * the Wishbone data port with random wait states and checks every store
 */
`timescale 1ns/1ps

module rvCoreTb;

   // About 120 instructions plus 20 bus transfers of up to 5 cycles, with margin
   localparam int timeoutCycles = 2000;
   localparam int storeCount = 18;

   logic        clk;
   logic        rst;
   logic [31:0] imemAddr;
   logic [31:0] imemData;
   logic        imemEn;
   logic        wbCyc;
   logic        wbStb;
   logic        wbWe;
   logic [3:0]  wbSel;
   logic [31:0] wbAdr;
   logic [31:0] wbDatW;
   logic [31:0] wbDatR;
   logic        wbAck;

   logic [31:0] imem [256];
   logic [31:0] dmem [128];
   logic [7:0]  fetchIdx;

   // Stores in program order
   logic [31:0] expAdr [storeCount] = '{
      32'h1F0, 32'h100, 32'h104, 32'h108, 32'h10C, 32'h110, 32'h114, 32'h1F0, 32'h118,
      32'h11C, 32'h1F0, 32'h120, 32'h1F0, 32'h124, 32'h128, 32'h12C, 32'h1F0, 32'h1FC};
   logic [31:0] expVal [storeCount] = '{
      32'h1, 32'hC, 32'hFFFFFFF8, 32'hF3, 32'hFFFFFFFE, 32'h1, 32'h0, 32'h2, 32'h12345000,
      32'h1040, 32'h3, 32'h4, 32'h4, 32'h37, 32'h9C, 32'hA5, 32'h5, 32'h1};
   int expTest [storeCount] = '{1, 2, 2, 2, 2, 2, 2, 2, 3, 3, 3, 4, 4, 5, 5, 5, 5, 6};

   int          storeIdx;
   int          failCount;
   int          testErrors;
   int          testsPassed;
   int          testsFailed;
   int          cycles;
   int          waitLeft;
   logic        busy;
   logic        done;
   logic [31:0] lfsr;

   clockGen clocks (
      .clk (clk),
      .rst (rst)
   );

   rvCore #(.resetVector(32'h0)) DUT (
      .clk      (clk),
      .rst      (rst),
      .imemAddr (imemAddr),
      .imemData (imemData),
      .imemEn   (imemEn),
      .wbCyc    (wbCyc),
      .wbStb    (wbStb),
      .wbWe     (wbWe),
      .wbSel    (wbSel),
      .wbAdr    (wbAdr),
      .wbDatW   (wbDatW),
      .wbDatR   (wbDatR),
      .wbAck    (wbAck)
   );

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic pickWait(output int waitCycles);
      logic lowBit;
      lfsr = lfsrStep(lfsr);
      lowBit = lfsr[0];
      lfsr = lfsrStep(lfsr);
      waitCycles = int'({lfsr[0], lowBit});
   endtask

   task automatic finishTest(input int num);
      if (testErrors == 0)
      begin
         testsPassed++;
         $display("test %0d passed", num);
      end
      else
      begin
         testsFailed++;
         $display("test %0d failed with %0d errors", num, testErrors);
      end
      testErrors = 0;
   endtask

   task automatic checkStore(input logic [31:0] adr, input logic [31:0] data);
      if (storeIdx >= storeCount)
      begin
         $display("Unexpected store to %h after the last expected one", adr);
         failCount++;
         testErrors++;
      end
      else
      begin
         assert (adr == expAdr[storeIdx] && data == expVal[storeIdx])
         else
         begin
            $display("CHECK FAILED test %0d wbAdr=%h wbDatW=%h expected wbAdr=%h wbDatW=%h",
                     expTest[storeIdx], adr, data, expAdr[storeIdx], expVal[storeIdx]);
            failCount++;
            testErrors++;
         end
         storeIdx++;
      end
      dmem[adr[8:2]] = data;
      if (adr == 32'h1F0)
         finishTest(int'(data));
      else if (adr == 32'h1FC && data == 32'h1)
      begin
         finishTest(6);
         done = 1'b1;
      end
   endtask

   // Synchronous instruction memory, output frozen while imemEn is low
   always @(posedge clk)
   begin
      if (imemEn)
      begin
         fetchIdx = imemAddr[9:2];
         #1;
         imemData = imem[fetchIdx];
      end
   end

   // Wishbone slave with 0 to 3 wait cycles before ack
   always @(posedge clk)
   begin
      if (wbAck)
      begin
         // Only full-word transfers exist
         assert (wbSel == 4'hF)
         else
         begin
            $display("CHECK FAILED wbSel=%h expected wbSel=%h", wbSel, 4'hF);
            failCount++;
            testErrors++;
         end
         if (wbWe)
            checkStore(wbAdr, wbDatW);
         #1;
         wbAck = 1'b0;
      end
      else if (wbCyc && wbStb && !rst)
      begin
         if (!busy)
         begin
            busy = 1'b1;
            pickWait(waitLeft);
         end
         if (waitLeft == 0)
         begin
            busy = 1'b0;
            #1;
            wbDatR = dmem[wbAdr[8:2]];
            wbAck = 1'b1;
         end
         else
            waitLeft--;
      end
   end

   initial
   begin
      imemData = 32'h0;
      wbDatR = 32'h0;
      wbAck = 1'b0;
      lfsr = 32'ha880;
      storeIdx = 0;
      failCount = 0;
      testErrors = 0;
      testsPassed = 0;
      testsFailed = 0;
      cycles = 0;
      waitLeft = 0;
      busy = 1'b0;
      done = 1'b0;
      for (int i = 0; i < 256; i++)
         imem[i] = 32'h0;
      for (int i = 0; i < 128; i++)
         dmem[i] = 32'h0;
      $readmemh("verification/program.hex", imem);

      while (!done && cycles < timeoutCycles)
      begin
         @(posedge clk);
         cycles++;
      end

      if (!done)
      begin
         $display("Timeout: program never signalled completion in %0d cycles", cycles);
         $display("TEST FAILED");
      end
      else
      begin
         $display("Summary: %0d tests passed, %0d tests failed", testsPassed, testsFailed);
         if (failCount == 0 && testsFailed == 0)
            $display("TEST OK");
         else
            $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: verification/program.hex
// One instruction word per line, loaded from address 0
// Test markers are stores to 0x1F0, a store of 1 to 0x1FC ends the run
00100513 // addi x10,x0,1
1EA02823 // sw x10,0x1F0
00500093 // addi x1,x0,5
00708113 // addi x2,x1,7
10202023 // sw x2,0x100
FEC10193 // addi x3,x2,-20
10302223 // sw x3,0x104
0FF14213 // xori x4,x2,0xFF
10402423 // sw x4,0x108
4021D293 // srai x5,x3,2
10502623 // sw x5,0x10C
0011A313 // slti x6,x3,1
10602823 // sw x6,0x110
0011B393 // sltiu x7,x3,1
10702A23 // sw x7,0x114
12345437 // lui x8,0x12345
00001497 // auipc x9,1 at 0x40
00200513 // addi x10,x0,2
1EA02823 // sw x10,0x1F0
10802C23 // sw x8,0x118
10902E23 // sw x9,0x11C
00300513 // addi x10,x0,3
1EA02823 // sw x10,0x1F0
10002603 // lw x12,0x100
10402683 // lw x13,0x104
00D60733 // add x14,x12,x13
12E02023 // sw x14,0x120
00400513 // addi x10,x0,4
1EA02823 // sw x10,0x1F0
00000793 // addi x15,x0,0
00100813 // addi x16,x0,1
00B00893 // addi x17,x0,11
010787B3 // add x15,x15,x16
00180813 // addi x16,x16,1
FF181CE3 // bne x16,x17,-8
0080006F // jal x0,+8
10078793 // addi x15,x15,0x100 (must be squashed)
12F02223 // sw x15,0x124
020000EF // jal x1,+0x20
0A500913 // addi x18,x0,0xA5
13202623 // sw x18,0x12C
00500513 // addi x10,x0,5
1EA02823 // sw x10,0x1F0
00100513 // addi x10,x0,1
1EA02E23 // sw x10,0x1FC
0000006F // jal x0,0
12102423 // sw x1,0x128
00008067 // jalr x0,0(x1)

// File: flist.f
src/rvCorePkg.sv
src/regFile.sv
src/rvFetch.sv
src/rvDecode.sv
src/rvExecute.sv
src/rvResult.sv
src/rvCore.sv
verification/clockGen.sv
verification/rvCore_chk.sv
verification/rvCoreTb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module rvCoreTb -f flist.f
	@out="$$(./obj_dir/VrvCoreTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
